/* Makefile */
# Verilator build for the transmit DMA and its testbench.

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tx_dma_tb -f flist.f

sim:
	verilator --binary --top-module tx_dma_tb -f flist.f -o tx_dma_sim
	./obj_dir/tx_dma_sim > sim.log 2>&1; cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* flist.f */
logic/tx_dma_pkg.sv
logic/tx_dma_stat_if.sv
logic/tx_dma_rd_if.sv
logic/tx_dma_cq_parser.sv
logic/tx_dma_pkt_buffer.sv
logic/tx_dma_usr_tx.sv
logic/tx_dma_mi_regs.sv
logic/tx_dma_top.sv
verification/tx_dma_tb.sv

/* logic/tx_dma_cq_parser.sv */
// CQ packet parser.
// Reads the header beat, filters the packet by channel enable and writes
// accepted data words plus one descriptor into the packet buffer.
`timescale 1ns/1ps

module tx_dma_cq_parser import tx_dma_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [DATA_W-1:0] cq_data,
    input  logic              cq_sof,
    input  logic              cq_eof,
    input  logic              cq_src_rdy,
    output logic              cq_dst_rdy,
    input  logic              data_free_ok,
    input  logic              desc_free_ok,
    output logic              data_wr,
    output logic [DATA_W:0]   data_in,
    output logic              desc_wr,
    output pkt_desc_t         desc_in,
    tx_dma_stat_if.parser     stat
);

    parse_state_t          state;
    logic [CHAN_W-1:0]     chan_q;
    logic [META_W-1:0]     meta_q;
    logic [PKT_SIZE_W-1:0] byte_cnt;
    logic                  beat;
    logic                  hdr_take;
    logic [CHAN_W-1:0]     hdr_chan;

    assign hdr_chan = cq_data[META_W +: CHAN_W];

    // a dropped packet drains freely, otherwise both FIFOs must have room.
    assign cq_dst_rdy = (state == PS_DROP) ? 1'b1 : (data_free_ok && desc_free_ok);
    assign beat       = cq_src_rdy && cq_dst_rdy;
    assign hdr_take   = beat && (state == PS_IDLE) && cq_sof;

    assign stat.acc_vld  = hdr_take && stat.chan_en[hdr_chan];
    assign stat.drop_vld = hdr_take && !stat.chan_en[hdr_chan];
    assign stat.chan     = hdr_chan;

    assign data_wr = beat && (state == PS_ACCEPT);
    assign data_in = {cq_eof, cq_data};
    assign desc_wr = data_wr && cq_eof;

    assign desc_in.size = byte_cnt + PKT_SIZE_W'(BEAT_BYTES); // includes the eof word.
    assign desc_in.chan = chan_q;
    assign desc_in.meta = meta_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= PS_IDLE;
        end else begin
            case (state)
                PS_IDLE:   if (hdr_take) state <= stat.chan_en[hdr_chan] ? PS_ACCEPT : PS_DROP;
                PS_ACCEPT: if (beat && cq_eof) state <= PS_IDLE;
                PS_DROP:   if (beat && cq_eof) state <= PS_IDLE;
                default:   state <= PS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_take) begin
            chan_q   <= hdr_chan;
            meta_q   <= cq_data[META_W-1:0];
            byte_cnt <= '0;
        end else if (data_wr) begin
            byte_cnt <= byte_cnt + PKT_SIZE_W'(BEAT_BYTES);
        end
    end

    a_hdr_no_eof: assert property (@(posedge clk) disable iff (rst)
        hdr_take |-> !cq_eof);

    // a word written before eof leaves room for at least one more.
    a_size_max: assert property (@(posedge clk) disable iff (rst)
        data_wr |-> (byte_cnt < PKT_SIZE_W'(PKT_SIZE_MAX)));

endmodule

/* logic/tx_dma_mi_regs.sv */
// MI register block of the transmit DMA.
// Holds the channel enable mask and per-channel accepted and dropped
// packet counters. Reads answer one cycle after the request.
`timescale 1ns/1ps

module tx_dma_mi_regs import tx_dma_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [MI_W-1:0]   mi_addr,
    input  logic [MI_W-1:0]   mi_dwr,
    input  logic [MI_W/8-1:0] mi_be,
    input  logic              mi_rd,
    input  logic              mi_wr,
    output logic [MI_W-1:0]   mi_drd,
    output logic              mi_ardy,
    output logic              mi_drdy,
    tx_dma_stat_if.regs       stat
);

    logic [CHANNELS-1:0] chan_en;
    logic [CNT_W-1:0]    pkt_cnt [CHANNELS];
    logic [CNT_W-1:0]    drop_cnt [CHANNELS];
    logic                cnt_clear;
    logic [MI_W-1:0]     rd_val;

    assign mi_ardy      = 1'b1; // the block never stalls a request.
    assign stat.chan_en = chan_en;
    assign cnt_clear    = mi_wr && (mi_addr == REG_CNT_CLEAR);

    always_ff @(posedge clk) begin
        if (rst) begin
            chan_en <= '0;
        end else if (mi_wr && mi_addr == REG_CHAN_EN && mi_be[0]) begin
            chan_en <= mi_dwr[CHANNELS-1:0]; // only the low byte holds used bits.
        end
    end

    // clear has priority over an event landing in the same cycle.
    always_ff @(posedge clk) begin
        if (rst || cnt_clear) begin
            for (int i = 0; i < CHANNELS; i++) begin
                pkt_cnt[i]  <= '0;
                drop_cnt[i] <= '0;
            end
        end else begin
            if (stat.acc_vld) pkt_cnt[stat.chan] <= pkt_cnt[stat.chan] + 1'b1;
            if (stat.drop_vld) drop_cnt[stat.chan] <= drop_cnt[stat.chan] + 1'b1;
        end
    end

    always_comb begin
        rd_val = '0; // unmapped addresses read as zero.
        if (mi_addr == REG_CHAN_EN) begin
            rd_val = MI_W'(chan_en);
        end
        for (int i = 0; i < CHANNELS; i++) begin
            if (mi_addr == REG_PKT_CNT_BASE + MI_W'(4 * i)) rd_val = MI_W'(pkt_cnt[i]);
            if (mi_addr == REG_DROP_CNT_BASE + MI_W'(4 * i)) rd_val = MI_W'(drop_cnt[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mi_drdy <= 1'b0;
        end else begin
            mi_drdy <= mi_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (mi_rd) mi_drd <= rd_val;
    end

endmodule

/* logic/tx_dma_pkg.sv */
// Transmit DMA shared definitions.
// Sizes, MI register map, packet descriptor and FSM state types.
package tx_dma_pkg;

    localparam int CHANNELS      = 4;
    localparam int CHAN_W        = $clog2(CHANNELS);
    localparam int DATA_W        = 32;
    localparam int BEAT_BYTES    = DATA_W / 8;
    localparam int META_W        = 24;
    localparam int PKT_BEATS_MAX = 16;
    localparam int PKT_SIZE_MAX  = PKT_BEATS_MAX * BEAT_BYTES; // 64 bytes.
    localparam int PKT_SIZE_W    = $clog2(PKT_SIZE_MAX + 1);

    localparam int DATA_DEPTH = 64;
    localparam int DESC_DEPTH = 8;
    localparam int DATA_AW    = $clog2(DATA_DEPTH);
    localparam int DESC_AW    = $clog2(DESC_DEPTH);
    localparam int DATA_CNT_W = $clog2(DATA_DEPTH + 1);
    localparam int DESC_CNT_W = $clog2(DESC_DEPTH + 1);

    localparam int MI_W  = 32;
    localparam int CNT_W = 32;

    localparam logic [MI_W-1:0] REG_CHAN_EN       = 32'h00;
    localparam logic [MI_W-1:0] REG_CNT_CLEAR     = 32'h04;
    localparam logic [MI_W-1:0] REG_PKT_CNT_BASE  = 32'h10; // one word per channel.
    localparam logic [MI_W-1:0] REG_DROP_CNT_BASE = 32'h20;

    // one stored packet, 33 bits.
    typedef struct packed {
        logic [PKT_SIZE_W-1:0] size;
        logic [CHAN_W-1:0]     chan;
        logic [META_W-1:0]     meta;
    } pkt_desc_t;

    typedef enum logic [1:0] {PS_IDLE, PS_ACCEPT, PS_DROP} parse_state_t;

    typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

endpackage

/* logic/tx_dma_pkt_buffer.sv */
// Store-and-forward packet buffer.
// A circular data FIFO of words with a last flag and a descriptor FIFO.
// A descriptor is only written once its packet is complete.
`timescale 1ns/1ps

module tx_dma_pkt_buffer import tx_dma_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            data_wr,
    input  logic [DATA_W:0] data_in,
    output logic            data_free_ok,
    input  logic            desc_wr,
    input  pkt_desc_t       desc_in,
    output logic            desc_free_ok,
    tx_dma_rd_if.buffer     rd
);

    logic [DATA_W:0]       data_mem [DATA_DEPTH];
    logic [DATA_AW-1:0]    data_wr_ptr;
    logic [DATA_AW-1:0]    data_rd_ptr;
    logic [DATA_CNT_W-1:0] data_cnt;
    logic [DATA_CNT_W-1:0] data_cnt_nxt;

    pkt_desc_t             desc_mem [DESC_DEPTH];
    logic [DESC_AW-1:0]    desc_wr_ptr;
    logic [DESC_AW-1:0]    desc_rd_ptr;
    logic [DESC_CNT_W-1:0] desc_cnt;
    logic [DESC_CNT_W-1:0] desc_cnt_nxt;

    assign data_cnt_nxt = data_cnt + DATA_CNT_W'(data_wr) - DATA_CNT_W'(rd.data_rd);
    assign desc_cnt_nxt = desc_cnt + DESC_CNT_W'(desc_wr) - DESC_CNT_W'(rd.desc_rd);

    assign rd.data      = data_mem[data_rd_ptr][DATA_W-1:0];
    assign rd.data_last = data_mem[data_rd_ptr][DATA_W];
    assign rd.data_vld  = (data_cnt != '0);
    assign rd.desc      = desc_mem[desc_rd_ptr];
    assign rd.desc_vld  = (desc_cnt != '0);

    always_ff @(posedge clk) begin
        if (data_wr) data_mem[data_wr_ptr] <= data_in;
        if (desc_wr) desc_mem[desc_wr_ptr] <= desc_in;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_wr_ptr  <= '0;
            data_rd_ptr  <= '0;
            data_cnt     <= '0;
            desc_wr_ptr  <= '0;
            desc_rd_ptr  <= '0;
            desc_cnt     <= '0;
            data_free_ok <= 1'b0;
            desc_free_ok <= 1'b0;
        end else begin
            data_wr_ptr  <= data_wr_ptr + DATA_AW'(data_wr); // pointers wrap at the depth.
            data_rd_ptr  <= data_rd_ptr + DATA_AW'(rd.data_rd);
            data_cnt     <= data_cnt_nxt;
            desc_wr_ptr  <= desc_wr_ptr + DESC_AW'(desc_wr);
            desc_rd_ptr  <= desc_rd_ptr + DESC_AW'(rd.desc_rd);
            desc_cnt     <= desc_cnt_nxt;
            data_free_ok <= (data_cnt_nxt < DATA_CNT_W'(DATA_DEPTH)); // from the next level.
            desc_free_ok <= (desc_cnt_nxt < DESC_CNT_W'(DESC_DEPTH));
        end
    end

    a_data_no_overflow: assert property (@(posedge clk) disable iff (rst)
        data_wr |-> (data_cnt < DATA_CNT_W'(DATA_DEPTH)));
    a_desc_no_overflow: assert property (@(posedge clk) disable iff (rst)
        desc_wr |-> (desc_cnt < DESC_CNT_W'(DESC_DEPTH)));
    a_data_no_underflow: assert property (@(posedge clk) disable iff (rst)
        rd.data_rd |-> (data_cnt != '0));
    a_desc_no_underflow: assert property (@(posedge clk) disable iff (rst)
        rd.desc_rd |-> (desc_cnt != '0));

endmodule

/* logic/tx_dma_rd_if.sv */
// Read side of the packet buffer.
// Descriptor and data FIFO heads with their pop strobes.
`timescale 1ns/1ps

interface tx_dma_rd_if import tx_dma_pkg::*; ();

    pkt_desc_t         desc;
    logic              desc_vld;
    logic              desc_rd;   // pops one descriptor.
    logic [DATA_W-1:0] data;
    logic              data_last; // last word of a packet.
    logic              data_vld;
    logic              data_rd;

    modport buffer (
        output desc,
        output desc_vld,
        input  desc_rd,
        output data,
        output data_last,
        output data_vld,
        input  data_rd
    );

    modport tx (
        input  desc,
        input  desc_vld,
        output desc_rd,
        input  data,
        input  data_last,
        input  data_vld,
        output data_rd
    );

endinterface

/* logic/tx_dma_stat_if.sv */
// Status link between the CQ parser and the MI registers.
// Carries the channel enable mask and per-packet accept and drop events.
`timescale 1ns/1ps

interface tx_dma_stat_if import tx_dma_pkg::*; ();

    logic [CHANNELS-1:0] chan_en;  // enable mask from the registers.
    logic                acc_vld;  // packet accepted, one cycle at its header.
    logic                drop_vld; // packet dropped, one cycle at its header.
    logic [CHAN_W-1:0]   chan;

    modport parser (
        input  chan_en,
        output acc_vld,
        output drop_vld,
        output chan
    );

    modport regs (
        output chan_en,
        input  acc_vld,
        input  drop_vld,
        input  chan
    );

endinterface

/* logic/tx_dma_top.sv */
// Host-to-card transmit DMA top level.
// CQ packets are filtered per channel, buffered whole and sent out on the
// user MFB stream with size, channel and header meta.
`timescale 1ns/1ps

module tx_dma_top import tx_dma_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [DATA_W-1:0]     cq_data,
    input  logic                  cq_sof,
    input  logic                  cq_eof,
    input  logic                  cq_src_rdy,
    output logic                  cq_dst_rdy,
    output logic [DATA_W-1:0]     usr_data,
    output logic                  usr_sof,
    output logic                  usr_eof,
    output logic                  usr_src_rdy,
    input  logic                  usr_dst_rdy,
    output logic [PKT_SIZE_W-1:0] usr_pkt_size,
    output logic [CHAN_W-1:0]     usr_chan,
    output logic [META_W-1:0]     usr_hdr_meta,
    input  logic [MI_W-1:0]       mi_addr,
    input  logic [MI_W-1:0]       mi_dwr,
    input  logic [MI_W/8-1:0]     mi_be,
    input  logic                  mi_rd,
    input  logic                  mi_wr,
    output logic [MI_W-1:0]       mi_drd,
    output logic                  mi_ardy,
    output logic                  mi_drdy
);

    logic            data_wr;
    logic [DATA_W:0] data_in; // data word with the last flag on top.
    logic            desc_wr;
    pkt_desc_t       desc_in;
    logic            data_free_ok;
    logic            desc_free_ok;

    tx_dma_stat_if stat ();
    tx_dma_rd_if   rd ();

    tx_dma_cq_parser parser0 (
        .clk, .rst,
        .cq_data, .cq_sof, .cq_eof, .cq_src_rdy, .cq_dst_rdy,
        .data_free_ok, .desc_free_ok,
        .data_wr, .data_in, .desc_wr, .desc_in,
        .stat (stat.parser)
    );

    tx_dma_pkt_buffer buffer0 (
        .clk, .rst,
        .data_wr, .data_in, .data_free_ok,
        .desc_wr, .desc_in, .desc_free_ok,
        .rd (rd.buffer)
    );

    tx_dma_usr_tx usr_tx0 (
        .clk, .rst,
        .usr_data, .usr_sof, .usr_eof, .usr_src_rdy, .usr_dst_rdy,
        .usr_pkt_size, .usr_chan, .usr_hdr_meta,
        .rd (rd.tx)
    );

    tx_dma_mi_regs regs0 (
        .clk, .rst,
        .mi_addr, .mi_dwr, .mi_be, .mi_rd, .mi_wr,
        .mi_drd, .mi_ardy, .mi_drdy,
        .stat (stat.regs)
    );

endmodule

/* logic/tx_dma_usr_tx.sv */
// User MFB transmitter.
// Pops a descriptor with the first data word and streams the packet out
// through a registered beat stage, holding the metadata for every beat.
`timescale 1ns/1ps

module tx_dma_usr_tx import tx_dma_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    output logic [DATA_W-1:0]     usr_data,
    output logic                  usr_sof,
    output logic                  usr_eof,
    output logic                  usr_src_rdy,
    input  logic                  usr_dst_rdy,
    output logic [PKT_SIZE_W-1:0] usr_pkt_size,
    output logic [CHAN_W-1:0]     usr_chan,
    output logic [META_W-1:0]     usr_hdr_meta,
    tx_dma_rd_if.tx               rd
);

    tx_state_t state;
    pkt_desc_t meta_q;
    logic      fetching; // words of the current packet are still in the buffer.
    logic      xfer;
    logic      can_load;

    assign xfer     = usr_src_rdy && usr_dst_rdy;
    assign can_load = !usr_src_rdy || usr_dst_rdy;

    // the data words of a packet are always stored before its descriptor.
    assign rd.desc_rd = (state == TX_IDLE) && rd.desc_vld && rd.data_vld && can_load;
    assign rd.data_rd = (state == TX_IDLE) ? rd.desc_rd
                                           : (fetching && rd.data_vld && can_load);

    assign usr_pkt_size = meta_q.size;
    assign usr_chan     = meta_q.chan;
    assign usr_hdr_meta = meta_q.meta;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= TX_IDLE;
            fetching    <= 1'b0;
            usr_src_rdy <= 1'b0;
        end else begin
            if (rd.desc_rd) state <= TX_SEND;
            else if (state == TX_SEND && xfer && usr_eof) state <= TX_IDLE;
            if (rd.data_rd) fetching <= !rd.data_last;
            if (rd.data_rd) usr_src_rdy <= 1'b1;
            else if (xfer) usr_src_rdy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd.desc_rd) meta_q <= rd.desc;
        if (rd.data_rd) begin
            usr_data <= rd.data;
            usr_sof  <= (state == TX_IDLE); // first word is popped with the descriptor.
            usr_eof  <= rd.data_last;
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        usr_src_rdy && !usr_dst_rdy |=> usr_src_rdy && $stable(usr_data)
            && $stable(usr_sof) && $stable(usr_eof));

endmodule

/* verification/tx_dma_tb.sv */
// Testbench for the transmit DMA.
// Random CQ packets, output stalls and MI accesses are checked against
// a model of the packet stream, the enable mask and the counters.
`timescale 1ns/1ps

module tx_dma_tb import tx_dma_pkg::*; ();

    typedef struct packed {
        logic                  sof;
        logic                  eof;
        logic [PKT_SIZE_W-1:0] size;
        logic [CHAN_W-1:0]     chan;
        logic [META_W-1:0]     meta;
        logic [DATA_W-1:0]     data;
    } beat_t;

    logic                  clk;
    logic                  rst;
    logic [DATA_W-1:0]     cq_data;
    logic                  cq_sof;
    logic                  cq_eof;
    logic                  cq_src_rdy;
    logic                  cq_dst_rdy;
    logic [DATA_W-1:0]     usr_data;
    logic                  usr_sof;
    logic                  usr_eof;
    logic                  usr_src_rdy;
    logic                  usr_dst_rdy;
    logic [PKT_SIZE_W-1:0] usr_pkt_size;
    logic [CHAN_W-1:0]     usr_chan;
    logic [META_W-1:0]     usr_hdr_meta;
    logic [MI_W-1:0]       mi_addr;
    logic [MI_W-1:0]       mi_dwr;
    logic [MI_W/8-1:0]     mi_be;
    logic                  mi_rd;
    logic                  mi_wr;
    logic [MI_W-1:0]       mi_drd;
    logic                  mi_ardy;
    logic                  mi_drdy;

    integer              seed;
    beat_t               exp_q [$]; // expected output beats in order.
    beat_t               got;
    beat_t               exp_b;
    beat_t               held;
    logic                stalled;
    logic [CHANNELS-1:0] en_mask;
    int                  acc_cnt [CHANNELS];
    int                  drop_cnt [CHANNELS];
    logic [MI_W-1:0]     rd_val;

    tx_dma_top dut0 (.*);

    always #5 clk = ~clk;

    always @(posedge clk) usr_dst_rdy <= 1'($random(seed)); // stalls about half the cycles.

    task automatic stop_with_fail(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
            stop_with_fail($sformatf("error at %0t: %s is 0x%0h, expected 0x%0h",
                                     $time, name, actual, expected));
    endtask

    task automatic mi_write(input logic [MI_W-1:0] addr, input logic [MI_W-1:0] data);
        mi_addr <= addr;
        mi_dwr  <= data;
        mi_be   <= 4'hf;
        mi_wr   <= 1'b1;
        @(posedge clk);
        mi_wr   <= 1'b0;
    endtask

    task automatic mi_read(input logic [MI_W-1:0] addr, output logic [MI_W-1:0] data);
        int lat;
        mi_addr <= addr;
        mi_rd   <= 1'b1;
        @(posedge clk);
        mi_rd   <= 1'b0;
        lat = 1;
        @(negedge clk);
        while (!mi_drdy) begin
            if (lat == 16) stop_with_fail("MI read got no mi_drdy within 16 cycles");
            @(negedge clk);
            lat++;
        end
        check_value("mi_drdy latency", 64'(lat), 64'd1);
        data = mi_drd;
        @(posedge clk);
    endtask

    // holds one CQ beat until the DUT takes it while src_rdy drops at random.
    task automatic send_beat(input logic [DATA_W-1:0] d, input logic sof, input logic eof);
        int tries;
        tries = 0;
        cq_data <= d;
        cq_sof  <= sof;
        cq_eof  <= eof;
        forever begin
            cq_src_rdy <= (($random(seed) & 3) != 0);
            @(negedge clk);
            if (cq_src_rdy && cq_dst_rdy) break;
            tries++;
            if (tries == 1000) stop_with_fail("CQ beat was not accepted within 1000 cycles");
            @(posedge clk);
        end
        @(posedge clk);
        cq_src_rdy <= 1'b0;
    endtask

    task automatic send_packet();
        int                beats;
        logic [CHAN_W-1:0] ch;
        logic [META_W-1:0] meta;
        logic [DATA_W-1:0] words [PKT_BEATS_MAX];
        beat_t             b;
        beats = 1 + int'($unsigned($random(seed)) % PKT_BEATS_MAX);
        ch    = CHAN_W'($random(seed));
        meta  = META_W'($random(seed));
        for (int i = 0; i < beats; i++) words[i] = $random(seed);
        if (en_mask[ch]) begin
            acc_cnt[ch]++;
            for (int i = 0; i < beats; i++) begin
                b = {(i == 0), (i == beats - 1), PKT_SIZE_W'(4 * beats), ch, meta, words[i]};
                exp_q.push_back(b);
            end
        end else begin
            drop_cnt[ch]++;
        end
        send_beat(DATA_W'({ch, meta}), 1'b1, 1'b0);
        for (int i = 0; i < beats; i++) send_beat(words[i], 1'b0, (i == beats - 1));
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0) begin
            if (cnt == 5000) stop_with_fail("expected packets did not leave the DUT in time");
            @(posedge clk);
            cnt++;
        end
        repeat (20) @(posedge clk); // room for any stray beat to show up.
    endtask

    task automatic check_counters();
        logic [MI_W-1:0] v;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            mi_read(REG_PKT_CNT_BASE + MI_W'(4 * ch), v);
            check_value($sformatf("pkt_cnt[%0d]", ch), 64'(v), 64'(acc_cnt[ch]));
            mi_read(REG_DROP_CNT_BASE + MI_W'(4 * ch), v);
            check_value($sformatf("drop_cnt[%0d]", ch), 64'(v), 64'(drop_cnt[ch]));
        end
    endtask

    always @(negedge clk) begin
        got = {usr_sof, usr_eof, usr_pkt_size, usr_chan, usr_hdr_meta, usr_data};
        if (!rst) begin
            check_value("mi_ardy", 64'(mi_ardy), 64'd1);
            if (stalled) begin
                check_value("usr_src_rdy while stalled", 64'(usr_src_rdy), 64'd1);
                check_value("usr_data while stalled", 64'(got.data), 64'(held.data));
                check_value("usr beat flags and metadata while stalled",
                            64'(got[$bits(beat_t)-1:DATA_W]), 64'(held[$bits(beat_t)-1:DATA_W]));
            end
            stalled = usr_src_rdy && !usr_dst_rdy;
            held    = got;
            if (usr_src_rdy && usr_dst_rdy) begin
                if (exp_q.size() == 0) stop_with_fail("output beat appeared with none expected");
                exp_b = exp_q.pop_front();
                check_value("usr_data", 64'(usr_data), 64'(exp_b.data));
                check_value("usr_sof", 64'(usr_sof), 64'(exp_b.sof));
                check_value("usr_eof", 64'(usr_eof), 64'(exp_b.eof));
                check_value("usr_pkt_size", 64'(usr_pkt_size), 64'(exp_b.size));
                check_value("usr_chan", 64'(usr_chan), 64'(exp_b.chan));
                check_value("usr_hdr_meta", 64'(usr_hdr_meta), 64'(exp_b.meta));
            end
        end
    end

    initial begin
        seed        = 32'h3b0a23d4;
        clk         = 1'b0;
        rst         = 1'b1;
        cq_data     = '0;
        cq_sof      = 1'b0;
        cq_eof      = 1'b0;
        cq_src_rdy  = 1'b0;
        usr_dst_rdy = 1'b0;
        mi_addr     = '0;
        mi_dwr      = '0;
        mi_be       = '0;
        mi_rd       = 1'b0;
        mi_wr       = 1'b0;
        stalled     = 1'b0;
        en_mask     = '0;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            acc_cnt[ch]  = 0;
            drop_cnt[ch] = 0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_value("cq_dst_rdy after reset", 64'(cq_dst_rdy), 64'd0);
        check_value("usr_src_rdy after reset", 64'(usr_src_rdy), 64'd0);
        check_value("mi_drdy after reset", 64'(mi_drdy), 64'd0);
        @(posedge clk);
        mi_read(REG_CHAN_EN, rd_val);
        check_value("chan_en after reset", 64'(rd_val), 64'd0);

        // four batches of 15 packets, each under a new enable mask.
        for (int batch = 0; batch < 4; batch++) begin
            en_mask = CHANNELS'($random(seed));
            mi_write(REG_CHAN_EN, MI_W'(en_mask));
            repeat (15) send_packet();
        end
        wait_drain();
        check_counters();

        mi_write(REG_CNT_CLEAR, '0);
        for (int ch = 0; ch < CHANNELS; ch++) begin
            acc_cnt[ch]  = 0;
            drop_cnt[ch] = 0;
        end
        check_counters();
        en_mask = CHANNELS'($random(seed));
        mi_write(REG_CHAN_EN, MI_W'(en_mask));
        repeat (12) send_packet();
        wait_drain();
        check_counters();

        mi_read(32'h08, rd_val);
        check_value("unmapped read at 0x08", 64'(rd_val), 64'd0);
        mi_read(32'h40, rd_val);
        check_value("unmapped read at 0x40", 64'(rd_val), 64'd0);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
